// ==== hw/net_input_unit.sv ====
/*
 * net_input_unit: input queue of one router port, with the
 * route computation for the message at the queue head
 */
module net_input_unit #(
  parameter int p_router_id   = 0,
  parameter int p_num_routers = 4,
  parameter int p_queue_depth = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  output logic              in_ready,
  input  net_pkg::net_msg_t in_msg,
  output logic              head_valid,
  output net_pkg::net_msg_t head_msg,
  output net_pkg::port_t    head_port,
  input  logic              deq
);

  localparam int c_ptr_nbits = (p_queue_depth > 1) ? $clog2(p_queue_depth) : 1;
  localparam int c_cnt_nbits = $clog2(p_queue_depth + 1);

  net_pkg::net_msg_t      mem [p_queue_depth];
  logic [c_ptr_nbits-1:0] wr_ptr;
  logic [c_ptr_nbits-1:0] rd_ptr;
  logic [c_cnt_nbits-1:0] count;
  logic                   enq;
  int                     route_dist;

  // --------------------
  // queue control
  assign enq        = in_valid && in_ready;
  assign in_ready   = (count != c_cnt_nbits'(p_queue_depth));
  assign head_valid = (count != '0);
  assign head_msg   = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq) begin
        wr_ptr <= (wr_ptr == c_ptr_nbits'(p_queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq) begin
        rd_ptr <= (rd_ptr == c_ptr_nbits'(p_queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({enq, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (enq) begin
      mem[wr_ptr] <= in_msg;
    end
  end

  // --------------------
  // route: forward distance around the ring, ties go forward
  always_comb begin
    route_dist = int'(head_msg.dest) - p_router_id;
    if (route_dist < 0) begin
      route_dist = route_dist + p_num_routers;
    end
    if (route_dist == 0) begin
      head_port = net_pkg::c_port_term;
    end else if (route_dist * 2 <= p_num_routers) begin
      head_port = net_pkg::c_port_next;
    end else begin
      head_port = net_pkg::c_port_prev;
    end
  end

  // a producer stalled by a full queue keeps its message
  a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_msg))
    else $error("input unit %0d producer dropped a stalled message", p_router_id);

  // the router only dequeues a queue that has a head
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    deq |-> head_valid)
    else $error("input unit %0d dequeue while empty", p_router_id);

endmodule

// ==== hw/net_output_arbiter.sv ====
/*
 * net_output_arbiter: round-robin arbiter and message mux for one router output
 */
module net_output_arbiter (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [net_pkg::c_num_ports-1:0]   req_valid,
  input  net_pkg::net_msg_t                 req_msg [net_pkg::c_num_ports],
  output logic [net_pkg::c_num_ports-1:0]   grant,
  output logic                              out_valid,
  input  logic                              out_ready,
  output net_pkg::net_msg_t                 out_msg
);

  localparam int c_n = net_pkg::c_num_ports;

  net_pkg::port_t prio_ptr;
  net_pkg::port_t win_idx;
  logic           lock;
  logic [c_n-1:0] lock_grant;
  logic [c_n-1:0] rr_grant;
  int             rr_idx;

  // --------------------
  // first requester at or after the pointer wins
  always_comb begin
    rr_grant = '0;
    rr_idx   = 0;
    for (int k = 0; k < c_n; k++) begin
      rr_idx = (int'(prio_ptr) + k) % c_n;
      if (rr_grant == '0 && req_valid[rr_idx]) begin
        rr_grant[rr_idx] = 1'b1;
      end
    end
  end

  // stalled output keeps last cycle's winner
  assign grant     = lock ? lock_grant : rr_grant;
  assign out_valid = |grant;

  always_comb begin
    out_msg = '0;
    win_idx = '0;
    for (int k = 0; k < c_n; k++) begin
      if (grant[k]) begin
        out_msg = req_msg[k];
        win_idx = net_pkg::port_t'(k);
      end
    end
  end

  // --------------------
  // pointer moves past the winner only when the message leaves
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_ptr   <= '0;
      lock       <= 1'b0;
      lock_grant <= '0;
    end else begin
      lock       <= out_valid && !out_ready;
      lock_grant <= grant;
      if (out_valid && out_ready) begin
        prio_ptr <= (win_idx == net_pkg::port_t'(c_n - 1)) ? '0 : win_idx + 2'd1;
      end
    end
  end

  // a granted input still has its head waiting for this output
  a_grant_requested: assert property (@(posedge clk) disable iff (!rst_n)
    (grant & ~req_valid) == '0)
    else $error("arbiter grant %b without request %b", grant, req_valid);

endmodule

// ==== hw/net_pkg.sv ====
/*
 * net_pkg: message format, node ids and port indices shared by the ring network
 */
package net_pkg;

  // --------------------
  // field widths
  localparam int c_node_id_nbits = 3;
  localparam int c_payload_nbits = 8;
  localparam int c_opaque_nbits  = 8;

  // router ports: prev ring link, local terminal, next ring link
  localparam int c_num_ports = 3;

  typedef logic [c_node_id_nbits-1:0] node_id_t;
  typedef logic [1:0]                 port_t;

  localparam port_t c_port_prev = 2'd0;
  localparam port_t c_port_term = 2'd1;
  localparam port_t c_port_next = 2'd2;

  // --------------------
  // one network message, 22 bits
  // opaque rides along untouched
  typedef struct packed {
    node_id_t                  dest;
    node_id_t                  src;
    logic [c_opaque_nbits-1:0] opaque;
    logic [c_payload_nbits-1:0] payload;
  } net_msg_t;

endpackage

// ==== hw/net_ring.sv ====
/*
 * net_ring: p_num_routers routers closed into a bidirectional ring,
 * only the terminal ports are visible outside
 */
module net_ring #(
  parameter int p_num_routers = 4,
  parameter int p_queue_depth = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [p_num_routers-1:0] term_in_valid,
  output logic [p_num_routers-1:0] term_in_ready,
  input  net_pkg::net_msg_t        term_in_msg [p_num_routers],
  output logic [p_num_routers-1:0] term_out_valid,
  input  logic [p_num_routers-1:0] term_out_ready,
  output net_pkg::net_msg_t        term_out_msg [p_num_routers]
);

  localparam int c_n = net_pkg::c_num_ports;

  // per-router port bundles, bit order next / term / prev
  logic [c_n-1:0]    rt_in_valid  [p_num_routers];
  logic [c_n-1:0]    rt_in_ready  [p_num_routers];
  net_pkg::net_msg_t rt_in_msg    [p_num_routers][c_n];
  logic [c_n-1:0]    rt_out_valid [p_num_routers];
  logic [c_n-1:0]    rt_out_ready [p_num_routers];
  net_pkg::net_msg_t rt_out_msg   [p_num_routers][c_n];

  for (genvar r = 0; r < p_num_routers; r++) begin : g_rt
    localparam int c_next = (r + 1) % p_num_routers;
    localparam int c_prev = (r + p_num_routers - 1) % p_num_routers;

    // --------------------
    // ring links: next output of r feeds prev input of r+1, and back
    assign rt_in_valid[r]  = {rt_out_valid[c_next][net_pkg::c_port_prev], term_in_valid[r],
                              rt_out_valid[c_prev][net_pkg::c_port_next]};
    assign rt_out_ready[r] = {rt_in_ready[c_next][net_pkg::c_port_prev], term_out_ready[r],
                              rt_in_ready[c_prev][net_pkg::c_port_next]};
    assign rt_in_msg[r]    = '{net_pkg::c_port_prev: rt_out_msg[c_prev][net_pkg::c_port_next],
                               net_pkg::c_port_term: term_in_msg[r],
                               net_pkg::c_port_next: rt_out_msg[c_next][net_pkg::c_port_prev]};

    // terminal side
    assign term_in_ready[r]  = rt_in_ready[r][net_pkg::c_port_term];
    assign term_out_valid[r] = rt_out_valid[r][net_pkg::c_port_term];
    assign term_out_msg[r]   = rt_out_msg[r][net_pkg::c_port_term];

    net_router #(
      .p_router_id   (r),
      .p_num_routers (p_num_routers),
      .p_queue_depth (p_queue_depth)
    ) router_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (rt_in_valid[r]),
      .in_ready  (rt_in_ready[r]),
      .in_msg    (rt_in_msg[r]),
      .out_valid (rt_out_valid[r]),
      .out_ready (rt_out_ready[r]),
      .out_msg   (rt_out_msg[r])
    );
  end

endmodule

// ==== hw/net_router.sv ====
/*
 * net_router: three-port ring router, prev / terminal / next,
 * with an input queue per port and a round-robin arbiter per output
 */
module net_router #(
  parameter int p_router_id   = 0,
  parameter int p_num_routers = 4,
  parameter int p_queue_depth = 2
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [net_pkg::c_num_ports-1:0] in_valid,
  output logic [net_pkg::c_num_ports-1:0] in_ready,
  input  net_pkg::net_msg_t               in_msg [net_pkg::c_num_ports],
  output logic [net_pkg::c_num_ports-1:0] out_valid,
  input  logic [net_pkg::c_num_ports-1:0] out_ready,
  output net_pkg::net_msg_t               out_msg [net_pkg::c_num_ports]
);

  localparam int c_n = net_pkg::c_num_ports;

  logic [c_n-1:0]    head_valid;
  net_pkg::net_msg_t head_msg  [c_n];
  net_pkg::port_t    head_port [c_n];
  logic [c_n-1:0]    deq;

  // indexed [output][input]
  logic [c_n-1:0]    req_valid [c_n];
  logic [c_n-1:0]    grant     [c_n];

  // --------------------
  // input side
  for (genvar i = 0; i < c_n; i++) begin : g_in
    net_input_unit #(
      .p_router_id   (p_router_id),
      .p_num_routers (p_num_routers),
      .p_queue_depth (p_queue_depth)
    ) input_unit_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid[i]),
      .in_ready   (in_ready[i]),
      .in_msg     (in_msg[i]),
      .head_valid (head_valid[i]),
      .head_msg   (head_msg[i]),
      .head_port  (head_port[i]),
      .deq        (deq[i])
    );
  end

  // --------------------
  // crossbar requests, each head asks exactly one output
  always_comb begin
    for (int o = 0; o < c_n; o++) begin
      for (int i = 0; i < c_n; i++) begin
        req_valid[o][i] = head_valid[i] && (head_port[i] == net_pkg::port_t'(o));
      end
    end
  end

  // a queue pops when the output that granted it transfers
  always_comb begin
    deq = '0;
    for (int i = 0; i < c_n; i++) begin
      for (int o = 0; o < c_n; o++) begin
        deq[i] = deq[i] | (grant[o][i] & out_ready[o]);
      end
    end
  end

  // --------------------
  // output side
  for (genvar o = 0; o < c_n; o++) begin : g_out
    net_output_arbiter output_arbiter_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid[o]),
      .req_msg   (head_msg),
      .grant     (grant[o]),
      .out_valid (out_valid[o]),
      .out_ready (out_ready[o]),
      .out_msg   (out_msg[o])
    );
  end

endmodule

// ==== net_ring.f ====
+incdir+include
hw/net_pkg.sv
hw/net_input_unit.sv
hw/net_output_arbiter.sv
hw/net_router.sv
hw/net_ring.sv
test/net_ring_tb.sv

// ==== include/net_ring_tb_checks.svh ====
/*
 * ring network testbench checks: compare tasks, error tally and final report
 */
`ifndef NET_RING_TB_CHECKS_SVH
`define NET_RING_TB_CHECKS_SVH

// --------------------
// tallies for the whole run
int error_count = 0;
int num_checks  = 0;
int num_tests   = 0;

task automatic check_msg(input string name, input net_pkg::net_msg_t expected,
                         input net_pkg::net_msg_t actual);
  num_checks++;
  if (actual !== expected) begin
    error_count++;
    $display("** Error at %0t: %s expected %h got %h", $time, name, expected, actual);
  end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
  num_checks++;
  if (actual !== expected) begin
    error_count++;
    $display("** Error at %0t: %s expected %b got %b", $time, name, expected, actual);
  end
endtask

task automatic check_count(input string name, input int expected, input int actual);
  num_checks++;
  if (actual != expected) begin
    error_count++;
    $display("** Error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
  end
endtask

// missing or extra deliveries, described in words
task automatic report_error(input string text);
  error_count++;
  $display("** Error at %0t: %s", $time, text);
endtask

// --------------------
// one line per test, errors counted since the test began
task automatic test_done(input string name, input int errors_at_start);
  num_tests++;
  $display("test %0d %s: %0d errors", num_tests, name, error_count - errors_at_start);
endtask

task automatic final_report();
  $display("%0d tests, %0d checks, %0d errors", num_tests, num_checks, error_count);
  if (error_count == 0) begin
    $display("PASS: all tests");
  end else begin
    $display("FAIL: see errors above");
  end
endtask

`endif

// ==== test/net_ring_tb.sv ====
/*
 * net_ring_tb: drives the terminal ports of a four-router ring and checks
 * every delivery against per source/destination queues of expected messages
 */
module net_ring_tb;

  localparam int c_nr          = 4;
  localparam int c_qd          = 2;
  localparam int c_period      = 8;
  localparam int c_max_flight  = 6;
  localparam int c_num_random  = 120;
  localparam int c_num_bp      = 40;
  localparam int c_total_msgs  = c_nr * c_nr + c_num_random + c_num_bp;

  logic              clk = 1'b0;
  logic              rst_n = 1'b0;
  logic [c_nr-1:0]   term_in_valid = '0;
  logic [c_nr-1:0]   term_in_ready;
  net_pkg::net_msg_t term_in_msg [c_nr] = '{default: '0};
  logic [c_nr-1:0]   term_out_valid;
  logic [c_nr-1:0]   term_out_ready = '1;
  net_pkg::net_msg_t term_out_msg [c_nr];

  `include "net_ring_tb_checks.svh"

  int                seed = 32'h4953;
  int                cycle = 0;
  int                launched = 0;
  int                delivered = 0;
  int                last_latency = 0;
  logic [7:0]        next_tag = '0;
  logic [c_nr-1:0]   in_fire = '0;
  logic [c_nr-1:0]   held = '0;
  net_pkg::net_msg_t held_msg [c_nr];

  // expected messages and their injection cycles, indexed src * c_nr + dest
  net_pkg::net_msg_t model_q  [c_nr*c_nr][$];
  int                inject_q [c_nr*c_nr][$];

  net_ring #(
    .p_num_routers (c_nr),
    .p_queue_depth (c_qd)
  ) net_ring_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .term_in_valid  (term_in_valid),
    .term_in_ready  (term_in_ready),
    .term_in_msg    (term_in_msg),
    .term_out_valid (term_out_valid),
    .term_out_ready (term_out_ready),
    .term_out_msg   (term_out_msg)
  );

  always #(c_period / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // --------------------
  // monitor on the falling edge, where valid, ready and messages are settled
  always @(negedge clk) begin : monitor
    net_pkg::net_msg_t m;
    int idx;
    if (rst_n) begin
      for (int s = 0; s < c_nr; s++) begin
        in_fire[s] = term_in_valid[s] && term_in_ready[s];
        if (in_fire[s]) begin
          idx = s * c_nr + int'(term_in_msg[s].dest);
          model_q[idx].push_back(term_in_msg[s]);
          inject_q[idx].push_back(cycle);
        end
      end
      for (int d = 0; d < c_nr; d++) begin
        // a stalled output must keep its message
        if (held[d]) begin
          check_bit($sformatf("term_out_valid[%0d]", d), 1'b1, term_out_valid[d]);
          check_msg($sformatf("term_out_msg[%0d]", d), held_msg[d], term_out_msg[d]);
        end
        held[d]     = term_out_valid[d] && !term_out_ready[d];
        held_msg[d] = term_out_msg[d];
        if (term_out_valid[d] && term_out_ready[d]) begin
          m   = term_out_msg[d];
          idx = int'(m.src) * c_nr + int'(m.dest);
          delivered++;
          if (int'(m.dest) != d) begin
            report_error($sformatf("message for terminal %0d delivered at terminal %0d",
                                   m.dest, d));
          end else if (model_q[idx].size() == 0) begin
            report_error($sformatf("extra delivery at terminal %0d from source %0d", d, m.src));
          end else begin
            check_msg($sformatf("term_out_msg[%0d]", d), model_q[idx].pop_front(), m);
            last_latency = cycle - inject_q[idx].pop_front();
          end
        end
      end
    end
  end

  // shortest ring distance between two nodes
  function automatic int ring_hops(input int s, input int d);
    int fwd;
    fwd = (d - s + c_nr) % c_nr;
    return (fwd < c_nr - fwd) ? fwd : c_nr - fwd;
  endfunction

  function automatic net_pkg::net_msg_t make_msg(input int s, input int d);
    net_pkg::net_msg_t m;
    m.dest    = net_pkg::node_id_t'(d);
    m.src     = net_pkg::node_id_t'(s);
    m.opaque  = next_tag;
    m.payload = 8'($random(seed));
    next_tag  = next_tag + 8'd1;
    return m;
  endfunction

  task automatic wait_delivered(input int target);
    int n;
    n = 0;
    while (delivered < target && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (delivered < target) begin
      report_error($sformatf("only %0d of %0d messages delivered after 200 cycles",
                             delivered, target));
    end
  endtask

  // one message on an idle ring, held until the terminal accepts it
  task automatic send_one(input int s, input int d);
    @(posedge clk);
    term_in_msg[s]   <= make_msg(s, d);
    term_in_valid[s] <= 1'b1;
    launched++;
    do @(posedge clk); while (!in_fire[s]);
    term_in_valid[s] <= 1'b0;
  endtask

  // random traffic, optionally with one sink blocked for the first cycles
  task automatic run_traffic(input int num_msgs, input int blocked, input int block_cycles);
    int made;
    int cyc;
    int d;
    logic [c_nr-1:0] pend;
    made = 0;
    cyc  = 0;
    pend = '0;
    // pend follows term_in_valid as it stands after this edge
    while (made < num_msgs || pend != '0 || cyc <= block_cycles) begin
      @(posedge clk);
      cyc++;
      for (int k = 0; k < c_nr; k++) begin
        term_out_ready[k] <= (k == blocked && cyc <= block_cycles) ? 1'b0
                                                                    : ({$random(seed)} % 4 != 0);
      end
      for (int s = 0; s < c_nr; s++) begin
        if (!pend[s] || in_fire[s]) begin
          if (made < num_msgs && launched - delivered < c_max_flight && $random(seed) % 2) begin
            d = (blocked >= 0 && $random(seed) % 2) ? blocked : {$random(seed)} % c_nr;
            term_in_msg[s]   <= make_msg(s, d);
            term_in_valid[s] <= 1'b1;
            pend[s] = 1'b1;
            made++;
            launched++;
          end else begin
            term_in_valid[s] <= 1'b0;
            pend[s] = 1'b0;
          end
        end
      end
    end
    term_out_ready <= '1;
    wait_delivered(launched);
  endtask

  // --------------------
  // watchdog, sized from the number of messages in all tests
  initial begin
    #(c_period * (c_total_msgs * 40 + 200));
    report_error("watchdog timeout, the tests did not finish");
    final_report();
    $finish;
  end

  initial begin : tests
    int errs;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    errs = error_count;
    @(negedge clk);
    for (int k = 0; k < c_nr; k++) begin
      check_bit($sformatf("term_out_valid[%0d]", k), 1'b0, term_out_valid[k]);
      check_bit($sformatf("term_in_ready[%0d]", k), 1'b1, term_in_ready[k]);
    end
    test_done("reset state", errs);

    errs = error_count;
    for (int s = 0; s < c_nr; s++) begin
      for (int d = 0; d < c_nr; d++) begin
        send_one(s, d);
        wait_delivered(launched);
        check_count($sformatf("latency %0d to %0d", s, d), ring_hops(s, d) + 1, last_latency);
      end
    end
    test_done("idle latency", errs);

    errs = error_count;
    run_traffic(c_num_random, -1, 0);
    test_done("random traffic", errs);

    errs = error_count;
    run_traffic(c_num_bp, 2, 60);
    check_count("delivered after release", launched, delivered);
    test_done("back-pressure", errs);

    errs = error_count;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_count("delivered", launched, delivered);
    for (int k = 0; k < c_nr * c_nr; k++) begin
      check_count($sformatf("model queue %0d size", k), 0, model_q[k].size());
    end
    for (int k = 0; k < c_nr; k++) begin
      check_bit($sformatf("term_out_valid[%0d]", k), 1'b0, term_out_valid[k]);
    end
    test_done("drain count", errs);

    final_report();
    $finish;
  end

endmodule
